/* cpu.f */
rv_isa_pkg.sv
pipe_pkg.sv
inst_memory.sv
decoder.sv
register_file.sv
hazard_unit.sv
alu.sv
data_memory.sv
cpu.sv
cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 -Wno-fatal
TOP       := cpu_tb
FILELIST  := cpu.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cpu_cases.txt */
// word 0: number of cases; per case: program length, program words,
// write count, then rd and wdata pairs in retirement order (all hex)
5
// case 1: alu and immediate ops, back-to-back dependences
12
00500093 00708113 002081B3 40118233 00F24293 00429313
001363B3 0023F433 0023D493 00322533 FFD00593 0015A613
0F05F693 00A6E713 001117B3 0017D833 00A00893 00000073
11
01 00000005  02 0000000C  03 00000011  04 0000000C
05 00000003  06 00000030  07 00000035  08 00000004
09 0000000D  0A 00000001  0B FFFFFFFD  0C 00000001
0D 000000F0  0E 000000FA  0F 00000180  10 0000000C
11 0000000A
// case 2: store, load, dependent add
0B
05500093 00800113 00112223 00412183 00118233 00412283
00508333 00612023 00012383 00A00893 00000073
08
01 00000055  02 00000008  03 00000055  04 000000AA
05 00000055  06 000000AA  07 000000AA  11 0000000A
// case 3: beq bne blt bge, taken and not taken
12
00300093 00300113 00208463 00100193 00209463 00200213
FFF00293 0012C663 00600313 00700393 0012D463 00800413
0050D463 00900493 0020C463 00A00513 00A00893 00000073
07
01 00000003  02 00000003  04 00000002  05 FFFFFFFF
08 00000008  0A 0000000A  11 0000000A
// case 4: jal and jalr link values and targets
0C
00C000EF 00500293 0100006F 00200113 000081E7 00400213
12345337 02900393 00038467 00900493 00A00893 00000073
08
01 00000004  02 00000002  03 00000014  05 00000005
06 12345000  07 00000029  08 00000024  11 0000000A
// case 5: ecall with x17 = 5 runs on, x17 = 10 halts
07
00500893 00000073 00100093 00A00893 00000073 00200113 00300193
03
11 00000005  01 00000001  11 0000000A

/* cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
  import pipe_pkg::*;

  localparam int mem_words = 64;
  localparam int addr_bits = $clog2(mem_words);
  localparam int case_words = 256;
  localparam int cycles_per_case = 200;
  localparam int tail_cycles = 6; // watch window after halt

  logic                 clk;
  logic                 reset;
  logic                 run;
  logic                 prog_we;
  logic [addr_bits-1:0] prog_addr;
  logic [31:0]          prog_data;
  retire_t              retire;
  logic                 is_halted;

  logic [31:0] cases_mem [case_words]; // flat image of the cases file
  integer      seed;
  int          cycle_count;
  int          cycle_limit; // 0 until the cases are read
  int          mismatch_count;
  int          missing_count;
  int          extra_count;
  int          other_count;

  cpu #(
    .imem_words(mem_words),
    .dmem_words(mem_words)
  ) i_cpu (
    .clk(clk),
    .reset(reset),
    .run(run),
    .prog_we(prog_we),
    .prog_addr(prog_addr),
    .prog_data(prog_data),
    .retire(retire),
    .is_halted(is_halted)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  function automatic int total_errors();
    return mismatch_count + missing_count + extra_count + other_count;
  endfunction

  task automatic print_counts();
    $display("errors: %0d (mismatch %0d, missing %0d, extra %0d, other %0d)",
             total_errors(), mismatch_count, missing_count, extra_count, other_count);
  endtask

  // watchdog over the whole run
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: program did not halt within %0d cycles", cycle_limit);
      other_count = other_count + 1;
      print_counts();
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic reset_core();
    @(posedge clk);
    reset <= 1'b1;
    run <= 1'b0; // core idle with pc parked at 0
    prog_we <= 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic load_program(input int base, input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
      prog_we <= 1'b1;
      prog_addr <= addr_bits'(i);
      prog_data <= cases_mem[base + i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
  endtask

  // one retirement against the next expected pair
  task automatic check_retire(input int case_no, input int exp_base, input int exp_count,
                              input int got, input int prog_base, input int prog_len);
    logic [4:0]  exp_rd;
    logic [31:0] exp_wdata;
    logic [31:0] inst_word;
    int          word_no;
    // pc must point at a program word whose rd field names the written register
    word_no = int'(retire.pc >> 2);
    if (retire.pc[1:0] != 2'b00 || word_no >= prog_len) begin
      $display("case %0d: retire.pc %h is not a word inside the program",
               case_no, retire.pc);
      other_count++;
    end else begin
      inst_word = cases_mem[prog_base + word_no];
      if (inst_word[11:7] !== retire.rd) begin
        $display("case %0d: instruction at retire.pc %h does not write x%0d",
                 case_no, retire.pc, retire.rd);
        other_count++;
      end
    end
    if (got >= exp_count) begin
      $display("case %0d: unexpected write to x%0d at pc %h after the expected list",
               case_no, retire.rd, retire.pc);
      extra_count++;
    end else begin
      exp_rd = cases_mem[exp_base + 2 * got][4:0];
      exp_wdata = cases_mem[exp_base + 2 * got + 1];
      if (retire.rd !== exp_rd) begin
        $display("Mismatch retire.rd: expected 0x%h, got 0x%h (case %0d, write %0d)",
                 exp_rd, retire.rd, case_no, got);
        mismatch_count++;
      end
      if (retire.wdata !== exp_wdata) begin
        $display("Mismatch retire.wdata: expected 0x%h, got 0x%h (case %0d, write %0d)",
                 exp_wdata, retire.wdata, case_no, got);
        mismatch_count++;
      end
    end
  endtask

  // sampled on the falling edge where outputs have settled
  task automatic run_case(input int case_no, input int exp_base, input int exp_count,
                          input int prog_base, input int prog_len);
    int   got;
    logic halted;
    got = 0;
    halted = 1'b0;
    while (!halted) begin
      @(negedge clk);
      if (retire.valid) begin
        check_retire(case_no, exp_base, exp_count, got, prog_base, prog_len);
        got++;
      end
      halted = is_halted;
    end
    repeat (tail_cycles) begin
      @(negedge clk);
      if (retire.valid) begin
        $display("case %0d: write to x%0d retired after the halt", case_no, retire.rd);
        extra_count++;
      end
      if (!is_halted) begin
        $display("case %0d: is_halted fell again before any reset", case_no);
        other_count++;
      end
    end
    if (got < exp_count) begin
      $display("case %0d: only %0d of %0d expected writes retired", case_no, got, exp_count);
      missing_count += exp_count - got;
    end
  endtask

  initial begin
    int n_cases;
    int ptr;
    int prog_base;
    int prog_len;
    int exp_len;
    int idle;
    seed = 35107;
    reset = 1'b1;
    run = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    cycle_count = 0;
    cycle_limit = 0;
    mismatch_count = 0;
    missing_count = 0;
    extra_count = 0;
    other_count = 0;
    $readmemh("cpu_cases.txt", cases_mem);
    n_cases = cases_mem[0];
    if (n_cases == 0) begin
      $display("no test cases could be read from cpu_cases.txt");
      other_count++;
    end
    cycle_limit = n_cases * cycles_per_case;
    repeat (3) @(posedge clk); // power-on reset
    reset <= 1'b0;
    ptr = 1;
    for (int c = 1; c <= n_cases; c++) begin
      prog_len = cases_mem[ptr];
      prog_base = ptr + 1;
      exp_len = cases_mem[prog_base + prog_len];
      reset_core();
      load_program(prog_base, prog_len);
      idle = ($unsigned($random(seed)) % 4) + 1; // gap between load and run
      repeat (idle) @(posedge clk);
      run <= 1'b1;
      run_case(c, prog_base + prog_len + 1, exp_len, prog_base, prog_len);
      ptr = prog_base + prog_len + 1 + 2 * exp_len; // next case header
    end
    print_counts();
    if (total_errors() == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* cpu.sv */
`timescale 1ns/1ps

module cpu #(
  parameter int imem_words = 256,
  parameter int dmem_words = 256
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          run,
  input  logic                          prog_we,
  input  logic [$clog2(imem_words)-1:0] prog_addr,
  input  logic [31:0]                   prog_data,
  output pipe_pkg::retire_t             retire,
  output logic                          is_halted
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  logic [31:0] pc;
  inst_t       fetched;
  logic        if_id_valid;
  inst_t       if_id_inst;
  logic [31:0] if_id_pc;
  ctrl_t       dec_ctrl;
  ctrl_t       id_ctrl;
  logic [31:0] id_imm;
  logic [4:0]  id_rs1;
  logic [4:0]  id_rs2;
  logic [31:0] rf_rs1;
  logic [31:0] rf_rs2;
  logic [31:0] id_rs1_val;
  logic [31:0] id_rs2_val;
  logic        stall;
  logic        freeze;
  fwd_sel_e    fwd_a;
  fwd_sel_e    fwd_b;
  fwd_sel_e    id_byp_a;
  fwd_sel_e    id_byp_b;
  id_ex_t      id_ex;
  ex_mem_t     ex_mem;
  mem_wb_t     mem_wb;
  logic [31:0] mem_fwd_val;
  logic [31:0] op_a;
  logic [31:0] op_b_reg;
  logic [31:0] op_b;
  logic [31:0] alu_result;
  logic        bcond;
  logic        take;
  logic [31:0] target;
  logic [31:0] dmem_rdata;

  // one source mux for decode bypass and execute forwarding
  function automatic logic [31:0] pick(input fwd_sel_e sel, input logic [31:0] reg_val,
                                       input logic [31:0] mem_val, input logic [31:0] wb_val);
    case (sel)
      fwd_mem: return mem_val;
      fwd_wb:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  inst_memory #(.imem_words(imem_words)) i_inst_memory (
    .clk(clk),
    .prog_we(prog_we),
    .prog_addr(prog_addr),
    .prog_data(prog_data),
    .fetch_addr(pc),
    .inst(fetched)
  );

  assign freeze = id_ex.halt; // halting ecall past decode

  // redirect beats stall, nothing moves while frozen or idle
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (take) begin
      pc <= target;
    end else if (run && !stall && !freeze) begin
      pc <= pc + 32'd4;
    end
  end

  // IF/ID
  always_ff @(posedge clk) begin
    if (reset) begin
      if_id_valid <= 1'b0;
    end else if (take || !run) begin
      if_id_valid <= 1'b0; // wrong path or idle
    end else if (!stall && !freeze) begin
      if_id_valid <= 1'b1;
      if_id_inst <= fetched;
      if_id_pc <= pc;
    end
  end

  decoder i_decoder (
    .inst(if_id_inst),
    .ctrl(dec_ctrl),
    .imm(id_imm)
  );

  assign id_ctrl = if_id_valid ? dec_ctrl : '0;

  always_comb begin
    id_rs1 = if_id_inst.r_fmt.rs1;
    id_rs2 = if_id_inst.r_fmt.rs2;
    if (id_ctrl.is_ecall) id_rs1 = 5'd17;                      // call number in a7
    if (id_ctrl.alu_src && !id_ctrl.mem_write) id_rs2 = '0;    // imm in place of rs2
    if (!if_id_valid) begin
      id_rs1 = '0;
      id_rs2 = '0;
    end
  end

  register_file i_register_file (
    .clk(clk),
    .reset(reset),
    .rs1(id_rs1),
    .rs2(id_rs2),
    .rd(mem_wb.rd),
    .wdata(mem_wb.wdata),
    .we(mem_wb.reg_write),
    .rs1_data(rf_rs1),
    .rs2_data(rf_rs2)
  );

  hazard_unit i_hazard_unit (
    .id_rs1(id_rs1),
    .id_rs2(id_rs2),
    .id_is_ecall(id_ctrl.is_ecall),
    .ex_rs1(id_ex.rs1),
    .ex_rs2(id_ex.rs2),
    .ex_rd(id_ex.rd),
    .ex_mem_read(id_ex.ctrl.mem_read),
    .ex_mem(ex_mem),
    .mem_wb(mem_wb),
    .stall(stall),
    .fwd_a(fwd_a),
    .fwd_b(fwd_b),
    .id_byp_a(id_byp_a),
    .id_byp_b(id_byp_b)
  );

  assign mem_fwd_val = ex_mem.pc_to_reg ? ex_mem.pc_plus_4 : ex_mem.alu_out;
  assign id_rs1_val = pick(id_byp_a, rf_rs1, mem_fwd_val, mem_wb.wdata);
  assign id_rs2_val = pick(id_byp_b, rf_rs2, mem_fwd_val, mem_wb.wdata);

  // ID/EX, held under halt, bubble on flush or stall
  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex <= '0;
    end else if (!freeze) begin
      if (take || stall) begin
        id_ex <= '0;
      end else begin
        id_ex.ctrl <= id_ctrl;
        id_ex.pc <= if_id_pc;
        id_ex.rs1 <= id_rs1;
        id_ex.rs2 <= id_rs2;
        id_ex.rs1_data <= id_rs1_val;
        id_ex.rs2_data <= id_rs2_val;
        id_ex.imm <= id_imm;
        id_ex.rd <= id_ctrl.reg_write ? if_id_inst.r_fmt.rd : '0;
        id_ex.halt <= id_ctrl.is_ecall && id_rs1_val == 32'd10; // exit call
      end
    end
  end

  assign op_a = pick(fwd_a, id_ex.rs1_data, mem_fwd_val, mem_wb.wdata);
  assign op_b_reg = pick(fwd_b, id_ex.rs2_data, mem_fwd_val, mem_wb.wdata);
  assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b_reg;

  alu i_alu (
    .alu_op(id_ex.ctrl.alu_op),
    .funct3(id_ex.ctrl.funct3),
    .a(op_a),
    .b(op_b),
    .result(alu_result),
    .bcond(bcond)
  );

  // not-taken prediction resolved here
  assign take = id_ex.ctrl.is_jal || id_ex.ctrl.is_jalr || (id_ex.ctrl.is_branch && bcond);
  assign target = id_ex.ctrl.is_jalr ? {alu_result[31:1], 1'b0} : id_ex.pc + id_ex.imm;

  // EX/MEM
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem <= '0;
    end else begin
      ex_mem.reg_write <= id_ex.ctrl.reg_write;
      ex_mem.mem_read <= id_ex.ctrl.mem_read;
      ex_mem.mem_write <= id_ex.ctrl.mem_write;
      ex_mem.pc_to_reg <= id_ex.ctrl.pc_to_reg;
      ex_mem.alu_out <= alu_result;
      ex_mem.store_data <= op_b_reg;
      ex_mem.pc_plus_4 <= id_ex.pc + 32'd4;
      ex_mem.rd <= id_ex.rd;
      ex_mem.halt <= id_ex.halt;
    end
  end

  data_memory #(.dmem_words(dmem_words)) i_data_memory (
    .clk(clk),
    .addr(ex_mem.alu_out),
    .wdata(ex_mem.store_data),
    .mem_read(ex_mem.mem_read),
    .mem_write(ex_mem.mem_write),
    .rdata(dmem_rdata)
  );

  // MEM/WB, writeback value picked here
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb <= '0;
    end else begin
      mem_wb.reg_write <= ex_mem.reg_write;
      mem_wb.rd <= ex_mem.rd;
      mem_wb.wdata <= ex_mem.mem_read ? dmem_rdata : mem_fwd_val;
      mem_wb.pc <= ex_mem.pc_plus_4 - 32'd4;
      mem_wb.halt <= ex_mem.halt;
    end
  end

  assign retire = '{valid: mem_wb.reg_write && mem_wb.rd != '0,
                    pc: mem_wb.pc,
                    rd: mem_wb.rd,
                    wdata: mem_wb.wdata};

  assign is_halted = mem_wb.halt; // sticky, the ecall keeps refilling

endmodule

/* data_memory.sv */
`timescale 1ns/1ps

module data_memory #(
  parameter int dmem_words = 256
) (
  input  logic        clk,
  input  logic [31:0] addr,  // byte address
  input  logic [31:0] wdata,
  input  logic        mem_read,
  input  logic        mem_write,
  output logic [31:0] rdata
);

  logic [31:0] mem [dmem_words];
  logic [$clog2(dmem_words)-1:0] idx;

  assign idx = addr[2 +: $clog2(dmem_words)]; // wraps at depth

  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem[idx] <= wdata;
    end
  end

  assign rdata = mem_read ? mem[idx] : '0;

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu (
  input  rv_isa_pkg::alu_op_e alu_op,
  input  logic [2:0]          funct3,
  input  logic [31:0]         a,
  input  logic [31:0]         b,
  output logic [31:0]         result,
  output logic                bcond
);
  import rv_isa_pkg::*;

  logic lt; // signed, shared by slt and blt/bge

  assign lt = $signed(a) < $signed(b);

  always_comb begin
    case (alu_op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_sll:    result = a << b[4:0];
      alu_srl:    result = a >> b[4:0]; // logical only
      alu_slt:    result = {31'b0, lt};
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  // branch compare on the same operands
  always_comb begin
    case (funct3)
      f3_beq:  bcond = a == b;
      f3_bne:  bcond = a != b;
      f3_blt:  bcond = lt;
      f3_bge:  bcond = !lt;
      default: bcond = 1'b0;
    endcase
  end

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
  input  logic [4:0]         id_rs1,
  input  logic [4:0]         id_rs2,
  input  logic               id_is_ecall,
  input  logic [4:0]         ex_rs1,
  input  logic [4:0]         ex_rs2,
  input  logic [4:0]         ex_rd,
  input  logic               ex_mem_read,
  input  pipe_pkg::ex_mem_t  ex_mem,
  input  pipe_pkg::mem_wb_t  mem_wb,
  output logic               stall,
  output pipe_pkg::fwd_sel_e fwd_a,
  output pipe_pkg::fwd_sel_e fwd_b,
  output pipe_pkg::fwd_sel_e id_byp_a,
  output pipe_pkg::fwd_sel_e id_byp_b
);
  import pipe_pkg::*;

  logic load_use;
  logic ecall_wait;

  // youngest writer wins and x0 never matches
  function automatic fwd_sel_e pick_src(input logic [4:0] rs, input logic use_mem);
    if (rs == '0) return fwd_reg;
    if (use_mem && ex_mem.reg_write && ex_mem.rd == rs) return fwd_mem;
    if (mem_wb.reg_write && mem_wb.rd == rs) return fwd_wb;
    return fwd_reg;
  endfunction

  always_comb begin
    fwd_a = pick_src(ex_rs1, 1'b1);
    fwd_b = pick_src(ex_rs2, 1'b1);
    id_byp_a = pick_src(id_rs1, id_is_ecall); // mem path only for ecall
    id_byp_b = pick_src(id_rs2, 1'b0);
    // load in execute feeding decode
    load_use = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);
    // ecall needs x17 settled in decode
    ecall_wait = id_is_ecall && id_rs1 != '0 &&
                 (ex_rd == id_rs1 || (ex_mem.mem_read && ex_mem.rd == id_rs1));
    stall = load_use || ecall_wait;
  end

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic [31:0] wdata,
  input  logic        we,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin // x0 stays zero
      regs[rd] <= wdata;
    end
  end

  // no internal bypass, decode muxes the writeback value
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

/* decoder.sv */
`timescale 1ns/1ps

module decoder (
  input  rv_isa_pkg::inst_t inst,
  output pipe_pkg::ctrl_t   ctrl,
  output logic [31:0]       imm
);
  import rv_isa_pkg::*;

  // same funct3 map for register and immediate forms
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub);
    case (f3)
      f3_add_sub: return sub ? alu_sub : alu_add;
      f3_sll:     return alu_sll;
      f3_slt:     return alu_slt;
      f3_xor:     return alu_xor;
      f3_srl:     return alu_srl;
      f3_or:      return alu_or;
      f3_and:     return alu_and;
      default:    return alu_add; // sltu not in subset
    endcase
  endfunction

  always_comb begin
    ctrl = '0;
    imm = '0;
    ctrl.funct3 = inst.r_fmt.funct3;
    case (inst.r_fmt.opcode)
      op_r: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op = arith_op(inst.r_fmt.funct3, inst.r_fmt.funct7[5]);
      end
      op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.alu_op = arith_op(inst.i_fmt.funct3, 1'b0); // no subi
        imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
      end
      op_load: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.alu_src = 1'b1;
        imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
      end
      op_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src = 1'b1;
        imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
      end
      op_branch: begin
        ctrl.is_branch = 1'b1;
        ctrl.alu_op = alu_sub;
        imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
               inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
      end
      op_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.pc_to_reg = 1'b1;
        ctrl.is_jal = 1'b1;
        ctrl.alu_src = 1'b1;      // rs2 unused
        ctrl.alu_op = alu_pass_b;
        imm = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
               inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
      end
      op_jalr: begin
        ctrl.reg_write = 1'b1;
        ctrl.pc_to_reg = 1'b1;
        ctrl.is_jalr = 1'b1;
        ctrl.alu_src = 1'b1;      // target is rs1 + imm
        imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
      end
      op_lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.alu_op = alu_pass_b;
        imm = {inst.u_fmt.imm, 12'b0};
      end
      op_system: ctrl.is_ecall = 1'b1; // csr ops not decoded
      default: ;                       // bubble
    endcase
  end

endmodule

/* inst_memory.sv */
`timescale 1ns/1ps

module inst_memory #(
  parameter int imem_words = 256
) (
  input  logic                          clk,
  input  logic                          prog_we,
  input  logic [$clog2(imem_words)-1:0] prog_addr,
  input  logic [31:0]                   prog_data,
  input  logic [31:0]                   fetch_addr, // byte address
  output rv_isa_pkg::inst_t             inst
);
  import rv_isa_pkg::*;

  logic [31:0] mem [imem_words];
  logic [29:0] word_idx;

  assign word_idx = fetch_addr[31:2];

  // load port, only used while the core is idle
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // past the end reads as a nop
  assign inst = (word_idx < imem_words) ? mem[word_idx[$clog2(imem_words)-1:0]] : nop_word;

endmodule

/* pipe_pkg.sv */
package pipe_pkg;

  // decoded control, all zero is a bubble
  typedef struct packed {
    logic                reg_write;
    logic                mem_read;
    logic                mem_write;
    logic                alu_src;   // b operand from imm
    logic                pc_to_reg; // rd gets pc+4
    logic                is_branch;
    logic                is_jal;
    logic                is_jalr;
    logic                is_ecall;
    rv_isa_pkg::alu_op_e alu_op;
    logic [2:0]          funct3;
  } ctrl_t;

  typedef struct packed {
    ctrl_t       ctrl;
    logic [31:0] pc;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm;
    logic [4:0]  rd;   // zero when nothing is written
    logic        halt;
  } id_ex_t;

  typedef struct packed {
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic        pc_to_reg;
    logic [31:0] alu_out;
    logic [31:0] store_data;
    logic [31:0] pc_plus_4;
    logic [4:0]  rd;
    logic        halt;
  } ex_mem_t;

  typedef struct packed {
    logic        reg_write;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic [31:0] pc;
    logic        halt;
  } mem_wb_t;

  // operand source
  typedef enum logic [1:0] {
    fwd_reg,
    fwd_mem,
    fwd_wb
  } fwd_sel_e;

  // one register write seen at writeback
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] wdata;
  } retire_t;

endpackage

/* rv_isa_pkg.sv */
package rv_isa_pkg;

  // major opcodes
  localparam logic [6:0] op_r      = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 for arithmetic and logic
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl     = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  // funct3 for branches
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_blt = 3'b100;
  localparam logic [2:0] f3_bge = 3'b101;

  localparam logic [31:0] nop_word = 32'h0000_0013; // addi x0, x0, 0

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, six views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_slt,
    alu_pass_b  // lui, jal
  } alu_op_e;

endpackage
